/* src/upwb_pkg.sv */
`default_nettype none

package upwb_pkg;

	typedef logic [3:0]  up_adr_t;   // processor register address
	typedef logic [7:0]  up_dat_t;
	typedef logic [31:0] wb_adr_t;   // byte address
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;

	// register group taken from the upper two bits of the processor address
	typedef enum logic [1:0] {
		REG_DATA = 2'd0,
		REG_ADDR = 2'd1,
		REG_CTRL = 2'd2    // group 3 maps onto the same control/status byte
	} reg_group_t;

	typedef struct packed {
		wb_adr_t adr;
		wb_dat_t dat;
		logic    we;
		wb_sel_t sel;
		logic    stb;
		logic    cyc;
	} wb_req_t;

	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
	} wb_rsp_t;

	// --------------------
	// address map of the subsystem
	localparam int N_SLAVES      = 4;
	localparam int RAM_WORDS     = 16;
	localparam int SLAVE_IDX_LSB = 6;                    // bits 7:6 pick the slave
	localparam int SLAVE_IDX_W   = $clog2(N_SLAVES);
	localparam int WORD_IDX_LSB  = 2;                    // bits 5:2 pick the word
	localparam int WORD_IDX_W    = $clog2(RAM_WORDS);

	localparam wb_dat_t MISS_DATA = '1;  // answer for an unmapped address

endpackage

`default_nettype wire

/* src/up_wb_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module up_wb_bridge (
	input  wire                        clk_i,
	input  wire                        reset_i,
	input  wire upwb_pkg::up_adr_t     up_adr_i,
	input  wire upwb_pkg::up_dat_t     up_dat_i,
	output upwb_pkg::up_dat_t          up_dat_o,
	input  wire                        rd_i,
	input  wire                        wr_i,
	output upwb_pkg::wb_req_t          wb_req_o,
	input  wire upwb_pkg::wb_rsp_t     wb_rsp_i
);
	import upwb_pkg::*;

	logic [1:0] rd_hist;   // bit 1 is the older sample
	logic [1:0] wr_hist;
	logic       rd_rise;
	logic       wr_rise;
	reg_group_t grp;
	logic [1:0] byte_idx;
	wb_req_t    req_q;
	wb_dat_t    rd_word;
	logic       busy;
	logic       launch;
	logic       ack_seen;

	// --------------------
	// strobe edge detection
	always_ff @(posedge clk_i or posedge reset_i) begin
		if (reset_i) begin
			rd_hist <= 2'b00;
			wr_hist <= 2'b00;
		end else begin
			rd_hist <= {rd_hist[0], rd_i};
			wr_hist <= {wr_hist[0], wr_i};
		end
	end

	assign rd_rise = (rd_hist == 2'b01);
	assign wr_rise = (wr_hist == 2'b01);

	// groups 2 and 3 both land on the control byte
	assign grp      = up_adr_i[3] ? REG_CTRL : reg_group_t'(up_adr_i[3:2]);
	assign byte_idx = up_adr_i[1:0];

	assign launch   = wr_rise && (grp == REG_CTRL) && up_dat_i[7] && !busy;
	assign ack_seen = wb_rsp_i.ack && req_q.cyc;

	// --------------------
	// request registers and cycle control
	always_ff @(posedge clk_i or posedge reset_i) begin
		if (reset_i) begin
			req_q   <= '0;
			busy    <= 1'b0;
			rd_word <= '0;
		end else begin
			if (ack_seen) begin
				req_q.stb <= 1'b0;
				req_q.cyc <= 1'b0;
				busy      <= 1'b0;
				if (!req_q.we) rd_word <= wb_rsp_i.dat;  // only read cycles return data
			end
			if (wr_rise) begin
				unique case (grp)
					REG_DATA: req_q.dat[8*byte_idx +: 8] <= up_dat_i;
					REG_ADDR: req_q.adr[8*byte_idx +: 8] <= up_dat_i;
					REG_CTRL: begin
						if (launch) begin
							req_q.we  <= up_dat_i[6];
							req_q.sel <= up_dat_i[5:2];
							req_q.stb <= 1'b1;
							req_q.cyc <= 1'b1;
							busy      <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// --------------------
	// processor read port
	always_ff @(posedge clk_i or posedge reset_i) begin
		if (reset_i) begin
			up_dat_o <= '0;
		end else if (rd_rise) begin
			unique case (grp)
				REG_DATA: up_dat_o <= rd_word[8*byte_idx +: 8];
				REG_ADDR: up_dat_o <= req_q.adr[8*byte_idx +: 8];
				REG_CTRL: up_dat_o <= {1'b0, req_q.we, req_q.sel, 1'b0, busy};
			endcase
		end
	end

	assign wb_req_o = req_q;

	// a strobe stays up with cyc and unchanged fields until the slave answers
	a_stb_held: assert property (
		@(posedge clk_i) disable iff (reset_i)
		req_q.stb && !wb_rsp_i.ack |=> req_q.stb && req_q.cyc && $stable(req_q.adr)
			&& $stable(req_q.dat) && $stable(req_q.we) && $stable(req_q.sel)
	) else $error("request dropped or changed before ack");

	// a reply with no cycle open means some slave acked on its own
	a_ack_needs_cyc: assert property (
		@(posedge clk_i) disable iff (reset_i)
		wb_rsp_i.ack |-> req_q.cyc
	) else $error("ack seen without an open cycle");

endmodule

`default_nettype wire

/* src/wb_slave_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_slave_decoder (
	input  wire                                clk_i,
	input  wire                                reset_i,
	input  wire upwb_pkg::wb_req_t             wb_req_i,
	output logic [upwb_pkg::N_SLAVES-1:0]      slave_stb_o,
	output upwb_pkg::wb_rsp_t                  miss_rsp_o
);
	import upwb_pkg::*;

	logic                   req_stb;
	logic                   in_window;
	logic [SLAVE_IDX_W-1:0] slave_idx;
	logic                   miss_stb;
	logic                   miss_ack;

	assign req_stb   = wb_req_i.cyc && wb_req_i.stb;
	assign in_window = (wb_req_i.adr[$bits(wb_adr_t)-1:SLAVE_IDX_LSB+SLAVE_IDX_W] == '0);
	assign slave_idx = wb_req_i.adr[SLAVE_IDX_LSB +: SLAVE_IDX_W];

	// one-hot strobe for the addressed slave
	always_comb begin
		slave_stb_o = '0;
		if (req_stb && in_window) slave_stb_o[slave_idx] = 1'b1;
	end

	// --------------------
	// miss path
	assign miss_stb = req_stb && !in_window;

	always_ff @(posedge clk_i or posedge reset_i) begin
		if (reset_i) begin
			miss_ack <= 1'b0;
		end else begin
			miss_ack <= miss_stb && !miss_ack;  // single pulse per cycle
		end
	end

	assign miss_rsp_o.dat = MISS_DATA;
	assign miss_rsp_o.ack = miss_ack;

	// the addressed slave must not change while its strobe is held
	a_stb_steady: assert property (
		@(posedge clk_i) disable iff (reset_i)
		slave_stb_o != '0 |=> slave_stb_o == '0 || slave_stb_o == $past(slave_stb_o)
	) else $error("slave strobe moved to another slave mid-cycle");

endmodule

`default_nettype wire

/* src/wb_scratch_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_scratch_ram (
	input  wire                        clk_i,
	input  wire                        reset_i,
	input  wire upwb_pkg::wb_req_t     wb_req_i,
	input  wire                        stb_i,
	output upwb_pkg::wb_rsp_t          wb_rsp_o
);
	import upwb_pkg::*;

	wb_dat_t                mem [RAM_WORDS];
	logic [WORD_IDX_W-1:0]  word_idx;
	logic                   hit;
	logic                   ack_q;
	wb_dat_t                rd_q;

	assign word_idx = wb_req_i.adr[WORD_IDX_LSB +: WORD_IDX_W];

	// the strobe is still high on the ack edge, so mask it then
	assign hit = stb_i && !ack_q;

	// --------------------
	// storage
	always_ff @(posedge clk_i) begin
		if (hit && wb_req_i.we) begin
			for (int b = 0; b < $bits(wb_sel_t); b++) begin
				if (wb_req_i.sel[b]) begin
					mem[word_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
				end
			end
		end
		if (hit && !wb_req_i.we) begin
			rd_q <= mem[word_idx];
		end
	end

	// --------------------
	// acknowledge
	always_ff @(posedge clk_i or posedge reset_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	assign wb_rsp_o.dat = rd_q;   // meaningful only with ack on a read
	assign wb_rsp_o.ack = ack_q;

endmodule

`default_nettype wire

/* src/wb_response_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_response_mux (
	input  wire upwb_pkg::wb_rsp_t     slave_rsp_i [upwb_pkg::N_SLAVES],
	input  wire upwb_pkg::wb_rsp_t     miss_rsp_i,
	output upwb_pkg::wb_rsp_t          wb_rsp_o
);
	import upwb_pkg::*;

	logic [N_SLAVES:0] acks;   // top bit is the miss path

	always_comb begin
		acks[N_SLAVES] = miss_rsp_i.ack;
		for (int i = 0; i < N_SLAVES; i++) begin
			acks[i] = slave_rsp_i[i].ack;
		end
	end

	// --------------------
	// merge
	always_comb begin
		wb_rsp_o.ack = |acks;
		wb_rsp_o.dat = '0;
		if (miss_rsp_i.ack) begin
			wb_rsp_o.dat = miss_rsp_i.dat;
		end
		for (int i = 0; i < N_SLAVES; i++) begin
			if (slave_rsp_i[i].ack) wb_rsp_o.dat = slave_rsp_i[i].dat;
		end

		// with a single master only one responder may answer
		a_single_ack: assert final ($onehot0(acks))
			else $error("several responders acked together: %b", acks);
	end

endmodule

`default_nettype wire

/* src/upwb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module upwb_top (
	input  wire                        clk_i,
	input  wire                        reset_i,
	input  wire upwb_pkg::up_adr_t     up_adr_i,
	input  wire upwb_pkg::up_dat_t     up_dat_i,
	output wire upwb_pkg::up_dat_t     up_dat_o,
	input  wire                        rd_i,
	input  wire                        wr_i
);
	import upwb_pkg::*;

	wire wb_req_t       wb_req;
	wire [N_SLAVES-1:0] slave_stb;
	wire wb_rsp_t       slave_rsp [N_SLAVES];
	wire wb_rsp_t       miss_rsp;
	wire wb_rsp_t       wb_rsp;

	// --------------------
	// master side
	up_wb_bridge u_bridge (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.up_adr_i (up_adr_i),
		.up_dat_i (up_dat_i),
		.up_dat_o (up_dat_o),
		.rd_i     (rd_i),
		.wr_i     (wr_i),
		.wb_req_o (wb_req),
		.wb_rsp_i (wb_rsp)
	);

	wb_slave_decoder u_decoder (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.wb_req_i    (wb_req),
		.slave_stb_o (slave_stb),
		.miss_rsp_o  (miss_rsp)
	);

	// --------------------
	// slaves
	for (genvar i = 0; i < N_SLAVES; i++) begin : g_ram
		wb_scratch_ram u_ram (
			.clk_i    (clk_i),
			.reset_i  (reset_i),
			.wb_req_i (wb_req),     // shared request, own strobe
			.stb_i    (slave_stb[i]),
			.wb_rsp_o (slave_rsp[i])
		);
	end

	wb_response_mux u_rsp_mux (
		.slave_rsp_i (slave_rsp),
		.miss_rsp_i  (miss_rsp),
		.wb_rsp_o    (wb_rsp)
	);

endmodule

`default_nettype wire

/* test/upwb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module upwb_tb;
	import upwb_pkg::*;

	typedef struct packed {
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
	} txn_t;

	localparam int N_FIXED     = 16;
	localparam int N_RANDOM    = 24;
	localparam int N_TXN       = N_FIXED + N_RANDOM;
	localparam int MAX_POLLS   = 20;
	localparam int CYCLE_LIMIT = N_TXN * 120 + 500;
	localparam int MODEL_WORDS = N_SLAVES * RAM_WORDS;

	logic    clk;
	logic    reset;
	up_adr_t up_adr;
	up_dat_t up_wdat;
	up_dat_t up_rdat;
	logic    rd;
	logic    wr;

	txn_t    txns [N_TXN];
	wb_dat_t model_mem [MODEL_WORDS];   // mirror of all four RAMs, indexed by address bits 7:2
	int      n_checks;
	int      n_errors;
	int      cycles;

	upwb_top uut (
		.clk_i    (clk),
		.reset_i  (reset),
		.up_adr_i (up_adr),
		.up_dat_i (up_wdat),
		.up_dat_o (up_rdat),
		.rd_i     (rd),
		.wr_i     (wr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// helpers
	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic txn_t make_txn(input logic we, input wb_adr_t adr, input wb_dat_t dat,
			input wb_sel_t sel);
		txn_t t;
		t.we  = we;
		t.adr = adr;
		t.dat = dat;
		t.sel = sel;
		return t;
	endfunction

	function automatic wb_dat_t model_read(input wb_adr_t adr);
		if (adr[31:8] != '0) return MISS_DATA;   // outside the slave window
		return model_mem[adr[7:2]];
	endfunction

	task automatic model_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		if (adr[31:8] == '0) begin
			for (int b = 0; b < 4; b++) begin
				if (sel[b]) model_mem[adr[7:2]][8*b +: 8] = dat[8*b +: 8];
			end
		end
	endtask

	task automatic check_byte(input string name, input up_dat_t exp, input up_dat_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// --------------------
	// processor bus tasks, entered and left just after a rising edge
	task automatic up_write(input up_adr_t a, input up_dat_t d);
		up_adr  <= a;
		up_wdat <= d;
		wr      <= 1'b1;
		repeat (3) @(posedge clk);
		wr <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic up_read(input up_adr_t a, output up_dat_t d);
		up_adr <= a;
		rd     <= 1'b1;
		repeat (3) @(posedge clk);
		rd <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		d = up_rdat;
		@(posedge clk);
	endtask

	task automatic wb_cycle(input txn_t t, output wb_dat_t rdata);
		up_dat_t st;
		up_dat_t b;
		int      polls;
		for (int i = 0; i < 4; i++) up_write(up_adr_t'(4 + i), t.adr[8*i +: 8]);
		for (int i = 0; i < 4; i++) up_write(up_adr_t'(i), t.dat[8*i +: 8]);
		up_write(4'd8, {1'b1, t.we, t.sel, 2'b00});
		polls = 0;
		st    = 8'h01;
		while (st[0] && polls < MAX_POLLS) begin
			up_read(4'd8, st);
			polls++;
			if (st[0]) check_byte("status while busy", {1'b0, t.we, t.sel, 2'b01}, st);
		end
		if (st[0]) begin
			n_errors++;
			$display("busy still set after %0d status polls, cycle to %h never finished",
				polls, t.adr);
		end else begin
			check_byte("status after cycle", {1'b0, t.we, t.sel, 2'b00}, st);
		end
		rdata = '0;
		if (!t.we) begin
			for (int i = 0; i < 4; i++) begin
				up_read(up_adr_t'(i), b);
				rdata[8*i +: 8] = b;
			end
		end
	endtask

	// --------------------
	// transaction table
	task automatic build_table();
		logic [31:0] rng;
		logic [31:0] r;
		logic [5:0]  widx;
		bit          planned [MODEL_WORDS];   // words that hold defined data when read
		txn_t        t;
		txns[0]  = make_txn(1'b1, 32'h0000_0000, 32'h1122_3344, 4'hF);
		txns[1]  = make_txn(1'b0, 32'h0000_0000, 32'h0, 4'hF);
		txns[2]  = make_txn(1'b1, 32'h0000_0000, 32'hAABB_CCDD, 4'h5);
		txns[3]  = make_txn(1'b0, 32'h0000_0000, 32'h0, 4'hF);
		txns[4]  = make_txn(1'b1, 32'h0000_000C, 32'hA0A0_A0A0, 4'hF);   // word 3 of each slave
		txns[5]  = make_txn(1'b1, 32'h0000_004C, 32'hB1B1_B1B1, 4'hF);
		txns[6]  = make_txn(1'b1, 32'h0000_008C, 32'hC2C2_C2C2, 4'hF);
		txns[7]  = make_txn(1'b1, 32'h0000_00CC, 32'hD3D3_D3D3, 4'hF);
		txns[8]  = make_txn(1'b0, 32'h0000_000C, 32'h0, 4'hF);
		txns[9]  = make_txn(1'b0, 32'h0000_004C, 32'h0, 4'hF);
		txns[10] = make_txn(1'b0, 32'h0000_008C, 32'h0, 4'hF);
		txns[11] = make_txn(1'b0, 32'h0000_00CC, 32'h0, 4'hF);
		txns[12] = make_txn(1'b0, 32'h0000_1200, 32'h0, 4'hF);
		txns[13] = make_txn(1'b1, 32'h8000_0040, 32'hDEAD_BEEF, 4'hF);
		txns[14] = make_txn(1'b1, 32'h0000_004C, 32'h5A00_0000, 4'h8);
		txns[15] = make_txn(1'b0, 32'h0000_004C, 32'h0, 4'hF);
		for (int k = 0; k < N_FIXED; k++) begin
			t = txns[k];
			if (t.we && t.sel == 4'hF && t.adr[31:8] == '0) planned[t.adr[7:2]] = 1'b1;
		end
		rng = 32'd92259;
		for (int k = N_FIXED; k < N_TXN; k++) begin
			rng  = next_rand(rng);
			r    = rng;
			rng  = next_rand(rng);
			widx = r[5:0];
			t    = make_txn(r[8], {24'h0, widx, 2'b00}, rng, r[12:9]);
			if (!planned[widx]) begin
				t.we  = 1'b1;   // first touch of a word must write all of it
				t.sel = 4'hF;
			end
			if (!t.we && r[20:18] == 3'd0) t.adr[16] = 1'b1;
			if (t.we && t.sel == 4'hF) planned[widx] = 1'b1;
			txns[k] = t;
		end
	endtask

	// --------------------
	// main sequence
	initial begin
		txn_t    t;
		wb_dat_t got;
		up_dat_t b;
		int      errs_before;
		reset    = 1'b1;
		rd       = 1'b0;
		wr       = 1'b0;
		up_adr   = '0;
		up_wdat  = '0;
		n_checks = 0;
		n_errors = 0;
		build_table();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		errs_before = n_errors;
		up_read(4'd8, b);
		check_byte("status after reset", 8'h00, b);
		for (int i = 0; i < 4; i++) up_write(up_adr_t'(4 + i), up_dat_t'(8'h12 + 8'h22 * i));
		for (int i = 0; i < 4; i++) up_write(up_adr_t'(i), up_dat_t'(8'hE0 + i));
		for (int i = 0; i < 4; i++) begin
			up_read(up_adr_t'(4 + i), b);
			check_byte("address byte", up_dat_t'(8'h12 + 8'h22 * i), b);
		end
		$display("test reg: status and address readback, %s",
			(n_errors == errs_before) ? "ok" : "failed");

		for (int k = 0; k < N_TXN; k++) begin
			errs_before = n_errors;
			t = txns[k];
			wb_cycle(t, got);
			if (t.we) model_write(t.adr, t.dat, t.sel);
			else check_word("read data", model_read(t.adr), got);
			$display("test %0d: %s adr %h sel %h, %s", k, t.we ? "write" : "read ", t.adr,
				t.sel, (n_errors == errs_before) ? "ok" : "failed");
		end

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// run limit from the table length
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles without finishing the tests", cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/upwb_pkg.sv
src/up_wb_bridge.sv
src/wb_slave_decoder.sv
src/wb_scratch_ram.sv
src/wb_response_mux.sv
src/upwb_top.sv
test/upwb_tb.sv
